/* hw/mult_pkg.sv */
`default_nettype none

package mult_pkg;

    // architectural widths
    localparam int xlen       = 32;
    localparam int tag_width  = 5;
    localparam int prod_width = 2 * xlen;  // full product, also the stage datapath width

    // multiply ops, funct3 of the M extension taken modulo 4
    typedef enum logic [1:0] {
        m_mul    = 2'b00,
        m_mulh   = 2'b01,
        m_mulhsu = 2'b10,
        m_mulhu  = 2'b11
    } mult_func_e;

    // packet handed over by the issue logic
    typedef struct packed {
        logic [tag_width-1:0] tag;
        mult_func_e           func;
        logic [xlen-1:0]      rs1;
        logic [xlen-1:0]      rs2;
    } mult_issue_t;

    // packet returned to writeback
    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      result;
    } mult_result_t;

    // control word carried next to the data through the stage chain
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        mult_func_e           func;
    } mult_stage_ctl_t;

    // counter width able to hold the values 0 to n
    function automatic int inflight_width(input int n);
        return $clog2(n + 1);
    endfunction

endpackage

`default_nettype wire

/* hw/mult_operand_prep.sv */
`default_nettype none

module mult_operand_prep import mult_pkg::*; (
    input  mult_func_e             func,
    input  logic [xlen-1:0]        rs1,
    input  logic [xlen-1:0]        rs2,
    output logic [prod_width-1:0]  mcand,
    output logic [prod_width-1:0]  mplier
);

    // rs1 is signed for everything except mulhu
    always_comb begin
        case (func)
            m_mul, m_mulh, m_mulhsu: mcand = {{xlen{rs1[xlen-1]}}, rs1};
            default:                 mcand = {{xlen{1'b0}}, rs1};
        endcase
    end

    // rs2 is unsigned for both mulhsu and mulhu
    always_comb begin
        case (func)
            m_mul, m_mulh: mplier = {{xlen{rs2[xlen-1]}}, rs2};
            default:       mplier = {{xlen{1'b0}}, rs2};
        endcase
    end

    // mul keeps only the low half and no extension changes it

endmodule

`default_nettype wire

/* hw/mult_stage.sv */
`default_nettype none

module mult_stage import mult_pkg::*; #(
    parameter int shift = 16
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  logic [prod_width-1:0]  prev_sum,
    input  logic [prod_width-1:0]  mplier,
    input  logic [prod_width-1:0]  mcand,
    input  mult_stage_ctl_t        ctl_in,
    output logic [prod_width-1:0]  product_sum,
    output logic [prod_width-1:0]  next_mplier,
    output logic [prod_width-1:0]  next_mcand,
    output mult_stage_ctl_t        ctl_out
);

    logic [prod_width-1:0] partial_product;
    logic                  valid_q;
    logic [tag_width-1:0]  tag_q;
    mult_func_e            func_q;

    // only the low shift bits of the multiplier count in this stage
    assign partial_product = mplier[shift-1:0] * mcand;

    // datapath and payload advance only when not stalled
    always_ff @(posedge clock) begin
        if (!stall) begin
            product_sum <= prev_sum + partial_product;
            next_mplier <= mplier >> shift;  // consumed bits drop out
            next_mcand  <= mcand << shift;   // weight of the next slice
            tag_q       <= ctl_in.tag;
            func_q      <= ctl_in.func;
        end
    end

    // valid holds while stalled so nothing is lost on back-pressure
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= ctl_in.valid;
        end
    end

    assign ctl_out.valid = valid_q;
    assign ctl_out.tag   = tag_q;
    assign ctl_out.func  = func_q;

endmodule

`default_nettype wire

/* hw/mult_pipe.sv */
`default_nettype none

module mult_pipe import mult_pkg::*; #(
    parameter int num_stages = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   issue_valid,
    input  mult_issue_t            issue,
    input  logic [prod_width-1:0]  mcand,
    input  logic [prod_width-1:0]  mplier,
    output logic                   issue_accept,
    output mult_result_t           result,
    output logic                   data_ready
);

    localparam int shift = prod_width / num_stages;

    // entry i feeds stage i, entry i+1 is what stage i produces
    logic [prod_width-1:0] sum_chain    [num_stages+1];
    logic [prod_width-1:0] mplier_chain [num_stages+1];
    logic [prod_width-1:0] mcand_chain  [num_stages+1];
    mult_stage_ctl_t       ctl_chain    [num_stages+1];

    mult_stage_ctl_t       last_ctl;
    logic [prod_width-1:0] last_sum;

    // an issue seen during a stall is dropped, the issuer re-presents it
    assign issue_accept = issue_valid & ~stall;

    // head of the chain
    assign sum_chain[0]       = '0;  // running sum starts empty
    assign mplier_chain[0]    = mplier;
    assign mcand_chain[0]     = mcand;
    assign ctl_chain[0].valid = issue_accept;
    assign ctl_chain[0].tag   = issue.tag;
    assign ctl_chain[0].func  = issue.func;

    for (genvar i = 0; i < num_stages; i++) begin : g_stage
        mult_stage #(
            .shift (shift)
        ) u_stage (
            .clock       (clock),
            .reset       (reset),
            .stall       (stall),
            .prev_sum    (sum_chain[i]),
            .mplier      (mplier_chain[i]),
            .mcand       (mcand_chain[i]),
            .ctl_in      (ctl_chain[i]),
            .product_sum (sum_chain[i+1]),
            .next_mplier (mplier_chain[i+1]),
            .next_mcand  (mcand_chain[i+1]),
            .ctl_out     (ctl_chain[i+1])
        );
    end

    assign last_ctl = ctl_chain[num_stages];
    assign last_sum = sum_chain[num_stages];

    // low word for mul, high word for the three mulh variants
    always_comb begin
        result.tag = last_ctl.tag;
        if (last_ctl.func == m_mul) begin
            result.result = last_sum[xlen-1:0];
        end else begin
            result.result = last_sum[prod_width-1:xlen];
        end
    end

    // the result is taken in the cycle it is offered, unless stalled
    assign data_ready = last_ctl.valid & ~stall;

endmodule

`default_nettype wire

/* hw/mult_inflight_counter.sv */
`default_nettype none

module mult_inflight_counter import mult_pkg::*; #(
    parameter int num_stages = 4
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      issue_accept,
    input  logic                                      data_ready,
    output logic [inflight_width(num_stages)-1:0]     inflight,
    output logic                                      idle
);

    localparam int cnt_width = inflight_width(num_stages);

    logic [cnt_width-1:0] count_next;

    always_comb begin
        case ({issue_accept, data_ready})
            2'b10:   count_next = inflight + cnt_width'(1);  // new op entered
            2'b01:   count_next = inflight - cnt_width'(1);  // op left the unit
            default: count_next = inflight;                  // none, or one in and one out
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            inflight <= '0;
            idle     <= 1'b1;
        end else begin
            inflight <= count_next;
            idle     <= (count_next == '0);  // registered along with the count
        end
    end

endmodule

`default_nettype wire

/* hw/mult_unit.sv */
`default_nettype none

module mult_unit import mult_pkg::*; #(
    parameter int num_stages = 4  // must divide 64, between 1 and 8
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      stall,
    input  logic                                      issue_valid,
    input  mult_issue_t                               issue,
    output mult_result_t                              result,
    output logic                                      data_ready,
    output logic [inflight_width(num_stages)-1:0]     inflight,
    output logic                                      idle
);

    logic [prod_width-1:0] mcand;
    logic [prod_width-1:0] mplier;
    logic                  issue_accept;

    // extension depends only on the op, done before the first stage
    mult_operand_prep u_prep (
        .func   (issue.func),
        .rs1    (issue.rs1),
        .rs2    (issue.rs2),
        .mcand  (mcand),
        .mplier (mplier)
    );

    mult_pipe #(
        .num_stages (num_stages)
    ) u_pipe (
        .clock        (clock),
        .reset        (reset),
        .stall        (stall),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .mcand        (mcand),
        .mplier       (mplier),
        .issue_accept (issue_accept),
        .result       (result),
        .data_ready   (data_ready)
    );

    // occupancy seen by the issue logic
    mult_inflight_counter #(
        .num_stages (num_stages)
    ) u_counter (
        .clock        (clock),
        .reset        (reset),
        .issue_accept (issue_accept),
        .data_ready   (data_ready),
        .inflight     (inflight),
        .idle         (idle)
    );

endmodule

`default_nettype wire

/* dv/mult_unit_chk.sv */
`default_nettype none

module mult_unit_chk import mult_pkg::*; #(
    parameter int num_stages = 4
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   stall,
    input  logic                                   issue_accept,
    input  logic                                   data_ready,
    input  logic [inflight_width(num_stages)-1:0]  inflight,
    input  logic                                   idle
);

    timeunit 1ns;
    timeprecision 1ps;

    // bit i set when an accept happened i+1 edges ago with no stall since
    logic [num_stages-1:0] clean_age;

    always_ff @(posedge clock) begin
        if (reset) begin
            clean_age <= '0;
        end else begin
            clean_age[0] <= issue_accept;
            for (int i = 1; i < num_stages; i++) begin
                clean_age[i] <= clean_age[i-1] & ~stall;  // a stall drops tracking
            end
        end
    end

    a_no_ready_on_stall: assert property (@(posedge clock) disable iff (reset)
        stall |-> !data_ready)
        else $error("data_ready high while stall is high");

    a_ready_needs_inflight: assert property (@(posedge clock) disable iff (reset)
        data_ready |-> inflight != '0)
        else $error("data_ready with an empty in-flight count");

    a_inflight_bound: assert property (@(posedge clock) disable iff (reset)
        int'(inflight) <= num_stages)
        else $error("in-flight count above the number of stages");

    a_idle_matches: assert property (@(posedge clock) disable iff (reset)
        idle == (inflight == '0))
        else $error("idle disagrees with the in-flight count");

    // unstalled op reaches the output after exactly num_stages edges
    a_latency: assert property (@(posedge clock) disable iff (reset)
        clean_age[num_stages-1] && !stall |-> data_ready)
        else $error("result missing num_stages edges after an unstalled accept");

endmodule

bind mult_unit mult_unit_chk #(
    .num_stages (num_stages)
) u_chk (
    .clock        (clock),
    .reset        (reset),
    .stall        (stall),
    .issue_accept (issue_accept),
    .data_ready   (data_ready),
    .inflight     (inflight),
    .idle         (idle)
);

`default_nettype wire

/* dv/mult_unit_tb.sv */
`default_nettype none

module mult_unit_tb import mult_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_stages   = 4;
    localparam int reset_cycles = 10;
    localparam int directed_ops = 64;  // 4 functions x 16 operand pairs
    localparam int burst_ops    = 2 * num_stages;
    localparam int random_ops   = 400;
    localparam int drain_cycles = 4 * num_stages;
    // about 4 cycles per random op plus three drains
    localparam int stim_cycles  = reset_cycles + directed_ops + burst_ops
                                + 4 * random_ops + 3 * drain_cycles;
    localparam int cycle_limit  = 2 * stim_cycles + 100;

    logic                                   clock = 1'b0;
    logic                                   reset;
    logic                                   stall;
    logic                                   issue_valid;
    mult_issue_t                            issue;
    mult_result_t                           result;
    logic                                   data_ready;
    logic [inflight_width(num_stages)-1:0]  inflight;
    logic                                   idle;

    mult_result_t         expected_q[$];  // reference model results in issue order
    logic [tag_width-1:0] next_tag;
    int cycles;
    int checks;
    int errors;
    int accepted;
    int completed;
    int peak_inflight;
    int tests_done;

    mult_unit #(
        .num_stages (num_stages)
    ) dut (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue       (issue),
        .result      (result),
        .data_ready  (data_ready),
        .inflight    (inflight),
        .idle        (idle)
    );

    always #5ns clock = ~clock;

    // 33-bit operands carry the signedness and the 66-bit product holds any case
    function automatic mult_result_t model_result(input mult_issue_t op);
        logic signed [32:0] a;
        logic signed [32:0] b;
        logic signed [65:0] p;
        mult_result_t       r;
        a = {(op.func != m_mulhu) && op.rs1[31], op.rs1};
        b = {(op.func == m_mul || op.func == m_mulh) && op.rs2[31], op.rs2};
        p = 66'(a) * 66'(b);
        r.tag = op.tag;
        r.result = (op.func == m_mul) ? p[31:0] : p[63:32];
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic present_op(input mult_func_e func, input logic [31:0] rs1,
                              input logic [31:0] rs2);
        issue_valid <= 1'b1;
        issue.tag   <= next_tag;
        issue.func  <= func;
        issue.rs1   <= rs1;
        issue.rs2   <= rs2;
        next_tag = next_tag + tag_width'(1);
    endtask

    task automatic issue_op(input mult_func_e func, input logic [31:0] rs1,
                            input logic [31:0] rs2);
        present_op(func, rs1, rs2);
        @(posedge clock);
    endtask

    // issuer keeps a refused op on the bus until the unit takes it
    task automatic run_random(input int count);
        int   sent;
        logic pending;
        sent = 0;
        pending = 1'b0;
        while (sent < count) begin
            stall <= ($urandom % 4) == 0;
            if (!pending) begin
                if (($urandom % 5) < 3) begin
                    present_op(mult_func_e'(2'($urandom)), $urandom, $urandom);
                    pending = 1'b1;
                end else begin
                    issue_valid <= 1'b0;
                end
            end
            @(posedge clock);
            if (issue_valid && !stall) begin  // taken on this edge
                sent++;
                pending = 1'b0;
            end
        end
        issue_valid <= 1'b0;
        stall       <= 1'b0;
    endtask

    task automatic wait_drain(input string test_name);
        int waited;
        waited = 0;
        @(posedge clock);
        while (!(idle && expected_q.size() == 0) && waited < drain_cycles) begin
            @(posedge clock);
            waited++;
        end
        if (!idle || expected_q.size() != 0) begin
            $display("%s: unit still busy after %0d cycles", test_name, drain_cycles);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_done++;
        $display("test %-9s done, %0d checks so far, %0d new errors",
                 name, checks, errors - errors_before);
    endtask

    // scoreboard pops before it pushes since a result never belongs to this cycle's issue
    always @(posedge clock) begin
        mult_result_t exp_r;
        if (!reset) begin
            if (data_ready) begin
                completed++;
                if (expected_q.size() == 0) begin
                    $display("result with tag %h at %0t but nothing was outstanding",
                             result.tag, $time);
                    errors++;
                end else begin
                    exp_r = expected_q.pop_front();
                    check_value("result.tag", 32'(exp_r.tag), 32'(result.tag));
                    check_value("result.result", exp_r.result, result.result);
                end
            end
            if (issue_valid && !stall) begin
                expected_q.push_back(model_result(issue));
                accepted++;
            end
            if (int'(inflight) > peak_inflight) peak_inflight = int'(inflight);
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int          errs;
        logic [31:0] corners [4];
        corners = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0001};
        void'($urandom(32'hda8));
        reset       = 1'b1;
        stall       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        next_tag    = '0;
        checks      = 0;
        errors      = 0;
        accepted    = 0;
        completed   = 0;
        tests_done  = 0;
        peak_inflight = 0;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        errs = errors;
        repeat (3) @(posedge clock);
        check_value("data_ready", 0, 32'(data_ready));
        check_value("inflight", 0, 32'(inflight));
        check_value("idle", 1, 32'(idle));
        finish_test("reset", errs);

        errs = errors;
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    issue_op(mult_func_e'(f[1:0]), corners[i], corners[j]);
                end
            end
        end
        issue_valid <= 1'b0;
        wait_drain("directed");
        finish_test("directed", errs);

        errs = errors;
        peak_inflight = 0;
        repeat (burst_ops) issue_op(mult_func_e'(2'($urandom)), $urandom, $urandom);
        issue_valid <= 1'b0;
        wait_drain("burst");
        check_value("peak inflight", num_stages, peak_inflight);
        finish_test("burst", errs);

        errs = errors;
        run_random(random_ops);
        finish_test("random", errs);

        errs = errors;
        wait_drain("drain");
        check_value("expected_q.size", 0, expected_q.size());
        check_value("completed", accepted, completed);
        check_value("idle", 1, 32'(idle));
        finish_test("drain", errs);

        $display("summary: %0d tests, %0d checks, %0d errors, %0d operations",
                 tests_done, checks, errors, completed);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/mult_pkg.sv
hw/mult_operand_prep.sv
hw/mult_stage.sv
hw/mult_pipe.sv
hw/mult_inflight_counter.sv
hw/mult_unit.sv
dv/mult_unit_chk.sv
dv/mult_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := mult_unit_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation stopped early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
